// File: src/pkt_buffer_pkg.sv
`default_nettype none

package pkt_buffer_pkg;

    //////////////////////////////
    // widths and depth

    localparam int DATA_W  = 64;
    localparam int KEEP_W  = DATA_W / 8;
    localparam int ENTRY_W = 1 + KEEP_W + DATA_W;   // {last, keep, data}
    localparam int META_W  = 32;

    localparam int ADDR_W  = 6;
    localparam int DEPTH   = 1 << ADDR_W;

    //////////////////////////////
    // cpu request opcodes

    typedef enum logic [1:0] {
        OP_PKT_RD  = 2'd0,
        OP_PKT_WR  = 2'd1,
        OP_META_RD = 2'd2,
        OP_META_WR = 2'd3
    } cpu_op_t;

endpackage

`default_nettype wire

// File: src/buffer_ram.sv
`default_nettype none

// simple dual port, port a read/write, port b read only
module buffer_ram
    import pkt_buffer_pkg::*;
#(
    parameter int WIDTH = ENTRY_W
)
(
    input  wire              clk,
    input  wire              a_we,
    input  wire [ADDR_W-1:0] a_addr,
    input  wire [WIDTH-1:0]  a_wdata,
    output logic [WIDTH-1:0] a_rdata,
    input  wire [ADDR_W-1:0] b_addr,
    output logic [WIDTH-1:0] b_rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (a_we)
        begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];   // old word on a write
    end

    always_ff @(posedge clk)
    begin
        b_rdata <= mem[b_addr];
    end

    a_addr_known: assert property (@(posedge clk) a_we |-> !$isunknown(a_addr))
        else $error("buffer_ram: write with unknown address");

endmodule

`default_nettype wire

// File: src/cpu_access_arbiter.sv
`default_nettype none

// port a owner select, datapath writes first
module cpu_access_arbiter
    import pkt_buffer_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,

    input  wire               dp_wr_en,
    input  wire [ADDR_W-1:0]  dp_wr_addr,
    input  wire [ENTRY_W-1:0] dp_wr_entry,
    input  wire [META_W-1:0]  dp_wr_meta,

    input  wire               cpu_req_valid,
    input  wire cpu_op_t      cpu_req_op,
    input  wire [ADDR_W-1:0]  cpu_req_addr,
    input  wire [ENTRY_W-1:0] cpu_req_wdata,

    output logic [ADDR_W-1:0]  a_addr,
    output logic               pkt_a_we,
    output logic [ENTRY_W-1:0] pkt_a_wdata,
    output logic               meta_a_we,
    output logic [META_W-1:0]  meta_a_wdata,
    output logic               issue_valid,
    output cpu_op_t            issue_op
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT_DP_IDLE
    } arb_state_t;

    arb_state_t state, state_next;

    // held request
    cpu_op_t              hold_op;
    logic [ADDR_W-1:0]    hold_addr;
    logic [ENTRY_W-1:0]   hold_wdata;

    logic                 sel_valid;
    cpu_op_t              sel_op;
    logic [ADDR_W-1:0]    sel_addr;
    logic [ENTRY_W-1:0]   sel_wdata;

    //////////////////////////////
    // request source

    assign sel_valid = (state == ST_WAIT_DP_IDLE) || cpu_req_valid;
    assign sel_op    = (state == ST_WAIT_DP_IDLE) ? hold_op    : cpu_req_op;
    assign sel_addr  = (state == ST_WAIT_DP_IDLE) ? hold_addr  : cpu_req_addr;
    assign sel_wdata = (state == ST_WAIT_DP_IDLE) ? hold_wdata : cpu_req_wdata;

    //////////////////////////////
    // port a mux

    always_comb
    begin
        state_next   = state;
        a_addr       = dp_wr_addr;
        pkt_a_we     = dp_wr_en;
        pkt_a_wdata  = dp_wr_entry;
        meta_a_we    = dp_wr_en;
        meta_a_wdata = dp_wr_meta;
        issue_valid  = 1'b0;
        issue_op     = sel_op;

        if (dp_wr_en)
        begin
            if (state == ST_IDLE && cpu_req_valid)
            begin
                state_next = ST_WAIT_DP_IDLE;   // park it
            end
        end
        else if (sel_valid)
        begin
            state_next   = ST_IDLE;
            a_addr       = sel_addr;
            pkt_a_wdata  = sel_wdata;
            meta_a_wdata = sel_wdata[META_W-1:0];
            issue_valid  = 1'b1;
            unique case (sel_op)
                OP_PKT_WR:  pkt_a_we  = 1'b1;
                OP_META_WR: meta_a_we = 1'b1;
                default:    ;                   // reads need no enable
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && dp_wr_en && cpu_req_valid)
        begin
            hold_op    <= cpu_req_op;
            hold_addr  <= cpu_req_addr;
            hold_wdata <= cpu_req_wdata;
        end
    end

    // host may not issue while a request is parked
    no_req_while_held: assert property (@(posedge clk) disable iff (!rstn)
        state == ST_WAIT_DP_IDLE |-> !cpu_req_valid)
        else $error("cpu_access_arbiter: cpu request while one is held");

endmodule

`default_nettype wire

// File: src/cpu_result_pipe.sv
`default_nettype none

// two stage cpu response, stage one covers the ram read
module cpu_result_pipe
    import pkt_buffer_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,

    input  wire               issue_valid,
    input  wire cpu_op_t      issue_op,
    input  wire [ENTRY_W-1:0] pkt_a_rdata,
    input  wire [META_W-1:0]  meta_a_rdata,

    output logic               cpu_rsp_valid,
    output cpu_op_t            cpu_rsp_op,
    output logic [ENTRY_W-1:0] cpu_rsp_data
);

    logic    s1_valid;
    cpu_op_t s1_op;

    //////////////////////////////
    // valid chain

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            s1_valid      <= 1'b0;
            cpu_rsp_valid <= 1'b0;
        end
        else
        begin
            s1_valid      <= issue_valid;
            cpu_rsp_valid <= s1_valid;
        end
    end

    //////////////////////////////
    // opcode and data

    always_ff @(posedge clk)
    begin
        s1_op <= issue_op;
        if (s1_valid)
        begin
            cpu_rsp_op <= s1_op;
            unique case (s1_op)
                OP_PKT_RD:  cpu_rsp_data <= pkt_a_rdata;
                OP_META_RD: cpu_rsp_data <= ENTRY_W'(meta_a_rdata);   // zero extend
                default:    cpu_rsp_data <= '0;                       // write ack
            endcase
        end
    end

    // one request in flight at a time
    single_in_flight: assert property (@(posedge clk) disable iff (!rstn)
        !(s1_valid && cpu_rsp_valid))
        else $error("cpu_result_pipe: overlapping cpu requests");

endmodule

`default_nettype wire

// File: src/pkt_buffer_top.sv
`default_nettype none

module pkt_buffer_top
    import pkt_buffer_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,

    // datapath write
    input  wire               dp_wr_en,
    input  wire [ADDR_W-1:0]  dp_wr_addr,
    input  wire [DATA_W-1:0]  dp_wr_data,
    input  wire [KEEP_W-1:0]  dp_wr_keep,
    input  wire               dp_wr_last,
    input  wire [META_W-1:0]  dp_wr_meta,

    // datapath read
    input  wire               dp_rd_en,
    input  wire [ADDR_W-1:0]  dp_rd_addr,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    output logic [KEEP_W-1:0] out_keep,
    output logic              out_last,
    output logic [META_W-1:0] out_meta,

    // cpu
    input  wire               cpu_req_valid,
    input  wire cpu_op_t      cpu_req_op,
    input  wire [ADDR_W-1:0]  cpu_req_addr,
    input  wire [ENTRY_W-1:0] cpu_req_wdata,
    output logic               cpu_rsp_valid,
    output cpu_op_t            cpu_rsp_op,
    output logic [ENTRY_W-1:0] cpu_rsp_data
);

    logic [ENTRY_W-1:0] dp_wr_entry;
    logic [ENTRY_W-1:0] pkt_b_rdata;

    logic [ADDR_W-1:0]  a_addr;
    logic               pkt_a_we;
    logic [ENTRY_W-1:0] pkt_a_wdata;
    logic [ENTRY_W-1:0] pkt_a_rdata;
    logic               meta_a_we;
    logic [META_W-1:0]  meta_a_wdata;
    logic [META_W-1:0]  meta_a_rdata;

    logic               issue_valid;
    cpu_op_t            issue_op;

    assign dp_wr_entry = {dp_wr_last, dp_wr_keep, dp_wr_data};
    assign {out_last, out_keep, out_data} = pkt_b_rdata;

    cpu_access_arbiter u_arbiter (
        .clk(clk), .rstn(rstn),
        .dp_wr_en(dp_wr_en), .dp_wr_addr(dp_wr_addr),
        .dp_wr_entry(dp_wr_entry), .dp_wr_meta(dp_wr_meta),
        .cpu_req_valid(cpu_req_valid), .cpu_req_op(cpu_req_op),
        .cpu_req_addr(cpu_req_addr), .cpu_req_wdata(cpu_req_wdata),
        .a_addr(a_addr),
        .pkt_a_we(pkt_a_we), .pkt_a_wdata(pkt_a_wdata),
        .meta_a_we(meta_a_we), .meta_a_wdata(meta_a_wdata),
        .issue_valid(issue_valid), .issue_op(issue_op)
    );

    buffer_ram #(.WIDTH(ENTRY_W)) pkt_ram (
        .clk(clk),
        .a_we(pkt_a_we), .a_addr(a_addr), .a_wdata(pkt_a_wdata), .a_rdata(pkt_a_rdata),
        .b_addr(dp_rd_addr), .b_rdata(pkt_b_rdata)
    );

    buffer_ram #(.WIDTH(META_W)) meta_ram (
        .clk(clk),
        .a_we(meta_a_we), .a_addr(a_addr), .a_wdata(meta_a_wdata), .a_rdata(meta_a_rdata),
        .b_addr(dp_rd_addr), .b_rdata(out_meta)
    );

    cpu_result_pipe u_result_pipe (
        .clk(clk), .rstn(rstn),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .pkt_a_rdata(pkt_a_rdata), .meta_a_rdata(meta_a_rdata),
        .cpu_rsp_valid(cpu_rsp_valid), .cpu_rsp_op(cpu_rsp_op),
        .cpu_rsp_data(cpu_rsp_data)
    );

    // port b data lands one cycle after the address
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= dp_rd_en;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_pkt_buffer.sv
`default_nettype none

module tb_pkt_buffer
    import pkt_buffer_pkg::*;
();

    typedef enum logic [1:0] {
        K_DP_WR,
        K_DP_WR_CPU,
        K_DP_RD,
        K_CPU
    } row_kind_t;

    typedef struct packed {
        row_kind_t          kind;
        logic [ADDR_W-1:0]  addr;
        cpu_op_t            op;
        logic [ENTRY_W-1:0] data;
        logic [META_W-1:0]  meta;
    } row_t;

    localparam int RSP_TIMEOUT = 20;
    localparam int BUSY_CYCLES = 3;   // datapath writes during a contended request

    logic               clk;
    logic               rstn;
    logic               dp_wr_en;
    logic [ADDR_W-1:0]  dp_wr_addr;
    logic [DATA_W-1:0]  dp_wr_data;
    logic [KEEP_W-1:0]  dp_wr_keep;
    logic               dp_wr_last;
    logic [META_W-1:0]  dp_wr_meta;
    logic               dp_rd_en;
    logic [ADDR_W-1:0]  dp_rd_addr;
    logic               out_valid;
    logic [DATA_W-1:0]  out_data;
    logic [KEEP_W-1:0]  out_keep;
    logic               out_last;
    logic [META_W-1:0]  out_meta;
    logic               cpu_req_valid;
    cpu_op_t            cpu_req_op;
    logic [ADDR_W-1:0]  cpu_req_addr;
    logic [ENTRY_W-1:0] cpu_req_wdata;
    logic               cpu_rsp_valid;
    cpu_op_t            cpu_rsp_op;
    logic [ENTRY_W-1:0] cpu_rsp_data;

    row_t               rows[$];
    logic [ENTRY_W-1:0] pkt_model [DEPTH];
    logic [META_W-1:0]  meta_model [DEPTH];
    logic [31:0]        lcg_state;

    pkt_buffer_top dut (
        .clk(clk), .rstn(rstn),
        .dp_wr_en(dp_wr_en), .dp_wr_addr(dp_wr_addr), .dp_wr_data(dp_wr_data),
        .dp_wr_keep(dp_wr_keep), .dp_wr_last(dp_wr_last), .dp_wr_meta(dp_wr_meta),
        .dp_rd_en(dp_rd_en), .dp_rd_addr(dp_rd_addr), .out_valid(out_valid),
        .out_data(out_data), .out_keep(out_keep), .out_last(out_last), .out_meta(out_meta),
        .cpu_req_valid(cpu_req_valid), .cpu_req_op(cpu_req_op),
        .cpu_req_addr(cpu_req_addr), .cpu_req_wdata(cpu_req_wdata),
        .cpu_rsp_valid(cpu_rsp_valid), .cpu_rsp_op(cpu_rsp_op), .cpu_rsp_data(cpu_rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [ENTRY_W-1:0] random_entry();
        logic [95:0] bits;
        bits = {lcg_next(), lcg_next(), lcg_next()};
        return bits[ENTRY_W-1:0];
    endfunction

    function automatic logic [ENTRY_W-1:0] expected_rsp(input cpu_op_t op,
                                                        input logic [ADDR_W-1:0] addr);
        case (op)
            OP_PKT_RD:  return pkt_model[addr];
            OP_META_RD: return {{(ENTRY_W-META_W){1'b0}}, meta_model[addr]};
            default:    return '0;   // writes answer with zero
        endcase
    endfunction

    task automatic add_row(input row_kind_t kind, input int addr, input cpu_op_t op);
        row_t r;
        r.kind = kind;
        r.addr = ADDR_W'(addr);
        r.op   = op;
        r.data = random_entry();
        r.meta = lcg_next();
        rows.push_back(r);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [ENTRY_W-1:0] expected,
                               input logic [ENTRY_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive_dp_write(input logic [ADDR_W-1:0] addr,
                                  input logic [ENTRY_W-1:0] data, input logic [META_W-1:0] meta);
        dp_wr_en   = 1'b1;
        dp_wr_addr = addr;
        dp_wr_data = data[DATA_W-1:0];
        dp_wr_keep = data[DATA_W +: KEEP_W];
        dp_wr_last = data[ENTRY_W-1];
        dp_wr_meta = meta;
        pkt_model[addr]  = data;
        meta_model[addr] = meta;
    endtask

    // model takes cpu writes at request time
    task automatic drive_cpu(input row_t r, output logic [ENTRY_W-1:0] expected);
        expected = expected_rsp(r.op, r.addr);
        if (r.op == OP_PKT_WR)
        begin
            pkt_model[r.addr] = r.data;
        end
        else if (r.op == OP_META_WR)
        begin
            meta_model[r.addr] = r.data[META_W-1:0];
        end
        cpu_req_valid = 1'b1;
        cpu_req_op    = r.op;
        cpu_req_addr  = r.addr;
        cpu_req_wdata = r.data;
    endtask

    task automatic check_rsp(input int idx, input cpu_op_t op, input logic [ENTRY_W-1:0] expected);
        check_value($sformatf("row %0d rsp valid", idx), ENTRY_W'(1'b1), ENTRY_W'(cpu_rsp_valid));
        check_value($sformatf("row %0d rsp op", idx), ENTRY_W'(op), ENTRY_W'(cpu_rsp_op));
        check_value($sformatf("row %0d rsp data", idx), expected, cpu_rsp_data);
        next_cycle();
        check_value($sformatf("row %0d rsp drop", idx), '0, ENTRY_W'(cpu_rsp_valid));
    endtask

    //////////////////////////////
    // row handlers

    task automatic apply_row(input int idx, input row_t r);
        logic [ENTRY_W-1:0] expected;
        int                 waited;
        case (r.kind)
            K_DP_WR:
            begin
                drive_dp_write(r.addr, r.data, r.meta);
                next_cycle();
                dp_wr_en = 1'b0;
            end
            K_DP_RD:
            begin
                dp_rd_en   = 1'b1;
                dp_rd_addr = r.addr;
                next_cycle();
                dp_rd_en = 1'b0;
                check_value($sformatf("row %0d out_valid", idx), ENTRY_W'(1'b1),
                            ENTRY_W'(out_valid));
                check_value($sformatf("row %0d entry", idx), pkt_model[r.addr],
                            {out_last, out_keep, out_data});
                check_value($sformatf("row %0d meta", idx), ENTRY_W'(meta_model[r.addr]),
                            ENTRY_W'(out_meta));
                next_cycle();
                check_value($sformatf("row %0d out_valid drop", idx), '0, ENTRY_W'(out_valid));
            end
            K_CPU:
            begin
                drive_cpu(r, expected);
                next_cycle();
                cpu_req_valid = 1'b0;
                check_value($sformatf("row %0d early rsp", idx), '0, ENTRY_W'(cpu_rsp_valid));
                next_cycle();
                check_rsp(idx, r.op, expected);
            end
            K_DP_WR_CPU:
            begin
                drive_cpu(r, expected);
                for (int i = 0; i < BUSY_CYCLES; i++)
                begin
                    drive_dp_write(ADDR_W'(r.addr + 1 + i), random_entry(), lcg_next());
                    next_cycle();
                    cpu_req_valid = 1'b0;
                    // junk on the idle request lines
                    cpu_req_op    = (r.op == OP_PKT_RD) ? OP_META_WR : OP_PKT_RD;
                    cpu_req_addr  = ~r.addr;
                    cpu_req_wdata = ~r.data;
                    check_value($sformatf("row %0d rsp while busy", idx), '0,
                                ENTRY_W'(cpu_rsp_valid));
                end
                dp_wr_en = 1'b0;
                waited   = 0;
                while (cpu_rsp_valid !== 1'b1 && waited < RSP_TIMEOUT)
                begin
                    next_cycle();
                    waited++;
                end
                if (cpu_rsp_valid !== 1'b1)
                begin
                    $display("no cpu response within timeout");
                    $display("TEST FAILED");
                    $fatal(1);
                end
                check_value($sformatf("row %0d latency", idx), ENTRY_W'(2), ENTRY_W'(waited));
                check_rsp(idx, r.op, expected);
            end
        endcase
    endtask

    //////////////////////////////
    // main sequence

    initial
    begin
        lcg_state     = 32'd24062;
        rstn          = 1'b0;
        dp_wr_en      = 1'b0;
        dp_wr_addr    = '0;
        dp_wr_data    = '0;
        dp_wr_keep    = '0;
        dp_wr_last    = 1'b0;
        dp_wr_meta    = '0;
        dp_rd_en      = 1'b0;
        dp_rd_addr    = '0;
        cpu_req_valid = 1'b0;
        cpu_req_op    = OP_PKT_RD;
        cpu_req_addr  = '0;
        cpu_req_wdata = '0;

        for (int a = 0; a < 6; a++)
        begin
            add_row(K_DP_WR, a, OP_PKT_RD);
        end
        for (int a = 0; a < 6; a++)
        begin
            add_row(K_DP_RD, a, OP_PKT_RD);
        end
        add_row(K_CPU, 2, OP_PKT_RD);
        add_row(K_CPU, 3, OP_META_RD);
        add_row(K_CPU, 10, OP_PKT_WR);
        add_row(K_CPU, 10, OP_META_WR);
        add_row(K_CPU, 10, OP_PKT_RD);
        add_row(K_CPU, 10, OP_META_RD);
        add_row(K_DP_RD, 10, OP_PKT_RD);
        add_row(K_DP_WR_CPU, 20, OP_PKT_WR);    // dp writes to 21..23
        add_row(K_DP_WR_CPU, 20, OP_META_WR);
        add_row(K_DP_WR_CPU, 2, OP_PKT_RD);     // read held behind writes to 3..5
        for (int a = 2; a < 6; a++)
        begin
            add_row(K_DP_RD, a, OP_PKT_RD);
        end
        for (int a = 20; a < 24; a++)
        begin
            add_row(K_DP_RD, a, OP_PKT_RD);
        end
        add_row(K_CPU, 21, OP_META_RD);

        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        check_value("reset out_valid", '0, ENTRY_W'(out_valid));
        check_value("reset cpu_rsp_valid", '0, ENTRY_W'(cpu_rsp_valid));

        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(i, rows[i]);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/pkt_buffer_pkg.sv
src/buffer_ram.sv
src/cpu_access_arbiter.sv
src/cpu_result_pipe.sv
src/pkt_buffer_top.sv
sim/tb_pkt_buffer.sv

// File: Makefile
TOP := tb_pkt_buffer

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the simulation, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@if grep -q "TEST OK" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
